//--- rtl/exec_config.svh
// Execute subsystem configuration.
// Data, shift and function-code widths, plus the queue depth
// that also sets the number of issue credits.

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// --------------------
// Datapath widths
// --------------------
`define EXEC_DATA_W      32 // Operand and result width.
`define EXEC_SHAMT_W     5  // Shift amount width.
`define EXEC_FUNC_W      6  // Function code width.

// --------------------
// Queue sizing
// --------------------
`define EXEC_QUEUE_DEPTH 4  // Entries and initial credits.

`endif

//--- rtl/execPkg.sv
// Execute subsystem package.
// Decoded opcode type and the MIPS funct codes for the SPECIAL
// and SPECIAL2 tables.

`include "exec_config.svh"

package execPkg;

    // Decoded operation, carried from issue through the queue.
    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO,
        OP_CLZ, OP_CLO,
        OP_ILLEGAL
    } execOpE;

    // --------------------
    // SPECIAL funct codes
    // --------------------
    parameter logic [`EXEC_FUNC_W-1:0] FN_SLL   = 6'h00;
    parameter logic [`EXEC_FUNC_W-1:0] FN_SRL   = 6'h02;
    parameter logic [`EXEC_FUNC_W-1:0] FN_SRA   = 6'h03;
    parameter logic [`EXEC_FUNC_W-1:0] FN_MFHI  = 6'h10;
    parameter logic [`EXEC_FUNC_W-1:0] FN_MFLO  = 6'h12;
    parameter logic [`EXEC_FUNC_W-1:0] FN_MULT  = 6'h18;
    parameter logic [`EXEC_FUNC_W-1:0] FN_MULTU = 6'h19;
    parameter logic [`EXEC_FUNC_W-1:0] FN_ADD   = 6'h20;
    parameter logic [`EXEC_FUNC_W-1:0] FN_ADDU  = 6'h21;
    parameter logic [`EXEC_FUNC_W-1:0] FN_SUB   = 6'h22;
    parameter logic [`EXEC_FUNC_W-1:0] FN_SUBU  = 6'h23;
    parameter logic [`EXEC_FUNC_W-1:0] FN_AND   = 6'h24;
    parameter logic [`EXEC_FUNC_W-1:0] FN_OR    = 6'h25;
    parameter logic [`EXEC_FUNC_W-1:0] FN_XOR   = 6'h26;
    parameter logic [`EXEC_FUNC_W-1:0] FN_NOR   = 6'h27;
    parameter logic [`EXEC_FUNC_W-1:0] FN_SLT   = 6'h2a;
    parameter logic [`EXEC_FUNC_W-1:0] FN_SLTU  = 6'h2b;

    // SPECIAL2 funct codes.
    parameter logic [`EXEC_FUNC_W-1:0] FN_CLZ   = 6'h20;
    parameter logic [`EXEC_FUNC_W-1:0] FN_CLO   = 6'h21;

endpackage

//--- rtl/aluCore.sv
// Combinational ALU.
// Arithmetic, logic, set-less-than and shift operations with
// carry, zero, overflow and negative flags.

`timescale 1ns/1ps
`include "exec_config.svh"

module aluCore (
    input  execPkg::execOpE           op,
    input  logic [`EXEC_DATA_W-1:0]   a,
    input  logic [`EXEC_DATA_W-1:0]   b,
    input  logic [`EXEC_SHAMT_W-1:0]  shamt,
    output logic [`EXEC_DATA_W-1:0]   out,
    output logic                      c,
    output logic                      z,
    output logic                      o,
    output logic                      n
);

    import execPkg::*;

    localparam int DW = `EXEC_DATA_W;

    logic [DW:0] sum;  // Carry in the top bit.
    logic [DW:0] diff; // Borrow in the top bit.
    logic        addOvf;
    logic        subOvf;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // Signed overflow when the result sign disagrees with the operands.
    assign addOvf = (a[DW-1] == b[DW-1]) && (sum[DW-1] != a[DW-1]);
    assign subOvf = (a[DW-1] != b[DW-1]) && (diff[DW-1] != a[DW-1]);

    // --------------------
    // Result and C/O
    // --------------------
    always_comb
    begin
        out = '0;
        c   = 1'b0;
        o   = 1'b0;
        case (op)
            OP_ADD:
            begin
                out = sum[DW-1:0];
                c   = sum[DW];
                o   = addOvf;
            end
            OP_ADDU:
            begin
                out = sum[DW-1:0];
                c   = sum[DW];
            end
            OP_SUB:
            begin
                out = diff[DW-1:0];
                c   = diff[DW];
                o   = subOvf;
            end
            OP_SUBU:
            begin
                out = diff[DW-1:0];
                c   = diff[DW];
            end
            OP_AND:  out = a & b;
            OP_OR:   out = a | b;
            OP_XOR:  out = a ^ b;
            OP_NOR:  out = ~(a | b);
            OP_SLT:  out = DW'($signed(a) < $signed(b));
            OP_SLTU: out = DW'(a < b);
            OP_SLL:  out = b << shamt; // Shifts act on B, as in MIPS.
            OP_SRL:  out = b >> shamt;
            OP_SRA:  out = $signed(b) >>> shamt;
            default: out = '0;         // Not an ALU operation.
        endcase
    end

    assign z = (out == '0);
    assign n = out[DW-1];

endmodule

//--- rtl/execIssue.sv
// Execute issue stage.
// Decodes the funct code into an opcode, picks B or the immediate
// and pushes the operation into the queue. A credit counter
// tracks free queue entries and gates inReady.

`timescale 1ns/1ps
`include "exec_config.svh"

module execIssue (
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic                      inValid,
    input  logic                      aluOp,
    input  logic                      mulOp,
    input  logic [`EXEC_FUNC_W-1:0]   func,
    input  logic [`EXEC_DATA_W-1:0]   a,
    input  logic [`EXEC_DATA_W-1:0]   b,
    input  logic [`EXEC_DATA_W-1:0]   immediate,
    input  logic [`EXEC_SHAMT_W-1:0]  shamt,
    input  logic                      aluSrc,
    input  logic                      creditReturn,
    output logic                      inReady,
    output logic                      pushValid,
    output execPkg::execOpE           pushOp,
    output logic [`EXEC_DATA_W-1:0]   pushA,
    output logic [`EXEC_DATA_W-1:0]   pushB,
    output logic [`EXEC_SHAMT_W-1:0]  pushShamt
);

    import execPkg::*;

    localparam int CRED_W = $clog2(`EXEC_QUEUE_DEPTH + 1);

    logic [CRED_W-1:0] credits;
    logic              accept;
    execOpE            decOp;

    assign inReady = (credits != '0); // One free slot is enough.
    assign accept  = inValid && inReady;

    // --------------------
    // Decode
    // --------------------
    always_comb
    begin
        decOp = OP_ILLEGAL;
        case ({aluOp, mulOp})
            2'b10:
                case (func)
                    FN_ADD:   decOp = OP_ADD;
                    FN_ADDU:  decOp = OP_ADDU;
                    FN_SUB:   decOp = OP_SUB;
                    FN_SUBU:  decOp = OP_SUBU;
                    FN_AND:   decOp = OP_AND;
                    FN_OR:    decOp = OP_OR;
                    FN_XOR:   decOp = OP_XOR;
                    FN_NOR:   decOp = OP_NOR;
                    FN_SLT:   decOp = OP_SLT;
                    FN_SLTU:  decOp = OP_SLTU;
                    FN_SLL:   decOp = OP_SLL;
                    FN_SRL:   decOp = OP_SRL;
                    FN_SRA:   decOp = OP_SRA;
                    FN_MULT:  decOp = OP_MULT;
                    FN_MULTU: decOp = OP_MULTU;
                    FN_MFHI:  decOp = OP_MFHI;
                    FN_MFLO:  decOp = OP_MFLO;
                    default:  decOp = OP_ILLEGAL;
                endcase
            2'b01:
                case (func)
                    FN_CLZ:   decOp = OP_CLZ;
                    FN_CLO:   decOp = OP_CLO;
                    default:  decOp = OP_ILLEGAL;
                endcase
            default: decOp = OP_ILLEGAL; // Neither or both tables.
        endcase
    end

    // Credits and push valid.
    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
        begin
            credits   <= CRED_W'(`EXEC_QUEUE_DEPTH);
            pushValid <= 1'b0;
        end
        else
        begin
            pushValid <= accept;
            case ({accept, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits; // Both or neither cancel.
            endcase
        end
    end

    // Push payload.
    always_ff @(posedge Clock)
    begin
        if (accept)
        begin
            pushOp    <= decOp;
            pushA     <= a;
            pushB     <= aluSrc ? immediate : b;
            pushShamt <= shamt;
        end
    end

endmodule

//--- rtl/execQueue.sv
// Decoded operation queue.
// Circular FIFO between issue and the execute unit. Each pop
// sends one credit back to issue on the following cycle.

`timescale 1ns/1ps
`include "exec_config.svh"

module execQueue #(
    parameter int DEPTH = 4
) (
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic                      pushValid,
    input  execPkg::execOpE           pushOp,
    input  logic [`EXEC_DATA_W-1:0]   pushA,
    input  logic [`EXEC_DATA_W-1:0]   pushB,
    input  logic [`EXEC_SHAMT_W-1:0]  pushShamt,
    input  logic                      popTake,
    output logic                      popValid,
    output execPkg::execOpE           popOp,
    output logic [`EXEC_DATA_W-1:0]   popA,
    output logic [`EXEC_DATA_W-1:0]   popB,
    output logic [`EXEC_SHAMT_W-1:0]  popShamt,
    output logic                      creditReturn
);

    import execPkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage.
    execOpE                   opMem    [DEPTH];
    logic [`EXEC_DATA_W-1:0]  aMem     [DEPTH];
    logic [`EXEC_DATA_W-1:0]  bMem     [DEPTH];
    logic [`EXEC_SHAMT_W-1:0] shamtMem [DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    assign popValid = (count != '0);
    assign popOp    = opMem[rdPtr];
    assign popA     = aMem[rdPtr];
    assign popB     = bMem[rdPtr];
    assign popShamt = shamtMem[rdPtr];

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end
        else
        begin
            creditReturn <= popTake; // One credit per pop.
            if (pushValid)
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (popTake)
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            case ({pushValid, popTake})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge Clock)
    begin
        if (pushValid)
        begin
            opMem[wrPtr]    <= pushOp;
            aMem[wrPtr]     <= pushA;
            bMem[wrPtr]     <= pushB;
            shamtMem[wrPtr] <= pushShamt;
        end
    end

endmodule

//--- rtl/execUnit.sv
// Execute unit.
// Pops the queue unless held, runs the ALU, multiply, HI/LO moves
// and leading-count operations, and registers result and flags.

`timescale 1ns/1ps
`include "exec_config.svh"

module execUnit (
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic                      hold,
    input  logic                      popValid,
    input  execPkg::execOpE           popOp,
    input  logic [`EXEC_DATA_W-1:0]   popA,
    input  logic [`EXEC_DATA_W-1:0]   popB,
    input  logic [`EXEC_SHAMT_W-1:0]  popShamt,
    output logic                      popTake,
    output logic                      resultValid,
    output logic [`EXEC_DATA_W-1:0]   result,
    output logic                      flagC,
    output logic                      flagZ,
    output logic                      flagO,
    output logic                      flagN,
    output logic                      illegal
);

    import execPkg::*;

    localparam int DW    = `EXEC_DATA_W;
    localparam int CNT_W = $clog2(DW + 1);

    logic [DW-1:0]   hi;
    logic [DW-1:0]   lo;
    logic [DW-1:0]   aluOut;
    logic            aluC, aluZ, aluO, aluN;
    logic [2*DW-1:0] prodS;
    logic [2*DW-1:0] prodU;
    logic [2*DW-1:0] prod;
    logic [DW-1:0]   resNext;
    logic            cNext, zNext, oNext, nNext, illNext;
    logic            isMul;

    // Leading run of bitVal from the MSB.
    function automatic logic [CNT_W-1:0] countLead(input logic [DW-1:0] value,
                                                   input logic bitVal);
        logic [CNT_W-1:0] count;
        logic             stop;
        count = '0;
        stop  = 1'b0;
        for (int i = DW - 1; i >= 0; i--)
        begin
            if (!stop && (value[i] == bitVal))
                count = count + 1'b1;
            else
                stop = 1'b1;
        end
        return count;
    endfunction

    aluCore aluCore_i (
        .op    (popOp   ),
        .a     (popA    ),
        .b     (popB    ),
        .shamt (popShamt),
        .out   (aluOut  ),
        .c     (aluC    ),
        .z     (aluZ    ),
        .o     (aluO    ),
        .n     (aluN    )
    );

    assign popTake = popValid && !hold;
    assign prodS   = $signed(popA) * $signed(popB);
    assign prodU   = {{DW{1'b0}}, popA} * {{DW{1'b0}}, popB};
    assign prod    = (popOp == OP_MULT) ? prodS : prodU;
    assign isMul   = (popOp == OP_MULT) || (popOp == OP_MULTU);

    // --------------------
    // Result select
    // --------------------
    always_comb
    begin
        resNext = aluOut;
        cNext   = aluC;
        zNext   = aluZ;
        oNext   = aluO;
        nNext   = aluN;
        illNext = 1'b0;
        case (popOp)
            OP_MULT, OP_MULTU:
            begin
                resNext = prod[DW-1:0];
                cNext   = 1'b0;
                oNext   = 1'b0;
                zNext   = (prod == '0);     // Whole product.
                nNext   = prod[2*DW-1];
            end
            OP_MFHI, OP_MFLO, OP_CLZ, OP_CLO:
            begin
                if (popOp == OP_MFHI)
                    resNext = hi;
                else if (popOp == OP_MFLO)
                    resNext = lo;
                else
                    resNext = DW'(countLead(popA, popOp == OP_CLO));
                cNext = 1'b0;
                oNext = 1'b0;
                zNext = (resNext == '0);
                nNext = resNext[DW-1];
            end
            OP_ILLEGAL:
            begin
                resNext = '0;
                cNext   = 1'b0;
                zNext   = 1'b0;
                oNext   = 1'b0;
                nNext   = 1'b0;
                illNext = 1'b1;
            end
            default: ;                      // ALU result as is.
        endcase
    end

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
        begin
            resultValid <= 1'b0;
            hi          <= '0;
            lo          <= '0;
        end
        else
        begin
            resultValid <= popTake;
            if (popTake && isMul)
            begin
                hi <= prod[2*DW-1:DW];
                lo <= prod[DW-1:0];
            end
        end
    end

    // Output payload.
    always_ff @(posedge Clock)
    begin
        if (popTake)
        begin
            result  <= resNext;
            flagC   <= cNext;
            flagZ   <= zNext;
            flagO   <= oNext;
            flagN   <= nNext;
            illegal <= illNext;
        end
    end

endmodule

//--- rtl/execTop.sv
// Execute subsystem top level.
// Issue feeds the operation queue under credit flow control,
// and the execute unit drains it into registered results.

`timescale 1ns/1ps
`include "exec_config.svh"

module execTop (
    input  logic                      Clock,
    input  logic                      rstN,
    input  logic                      hold,
    input  logic                      inValid,
    input  logic                      aluOp,
    input  logic                      mulOp,
    input  logic [`EXEC_FUNC_W-1:0]   func,
    input  logic [`EXEC_DATA_W-1:0]   a,
    input  logic [`EXEC_DATA_W-1:0]   b,
    input  logic [`EXEC_DATA_W-1:0]   immediate,
    input  logic [`EXEC_SHAMT_W-1:0]  shamt,
    input  logic                      aluSrc,
    output logic                      inReady,
    output logic                      resultValid,
    output logic [`EXEC_DATA_W-1:0]   result,
    output logic                      flagC,
    output logic                      flagZ,
    output logic                      flagO,
    output logic                      flagN,
    output logic                      illegal
);

    import execPkg::*;

    // Issue to queue.
    logic                     pushValid;
    execOpE                   pushOp;
    logic [`EXEC_DATA_W-1:0]  pushA, pushB;
    logic [`EXEC_SHAMT_W-1:0] pushShamt;
    logic                     creditReturn;

    // Queue to execute unit.
    logic                     popValid, popTake;
    execOpE                   popOp;
    logic [`EXEC_DATA_W-1:0]  popA, popB;
    logic [`EXEC_SHAMT_W-1:0] popShamt;

    execIssue issue_i (
        .Clock(Clock), .rstN(rstN), .inValid(inValid), .aluOp(aluOp), .mulOp(mulOp),
        .func(func), .a(a), .b(b), .immediate(immediate), .shamt(shamt),
        .aluSrc(aluSrc), .creditReturn(creditReturn), .inReady(inReady),
        .pushValid(pushValid), .pushOp(pushOp), .pushA(pushA), .pushB(pushB),
        .pushShamt(pushShamt)
    );

    execQueue #(.DEPTH(`EXEC_QUEUE_DEPTH)) queue_i (
        .Clock(Clock), .rstN(rstN), .pushValid(pushValid), .pushOp(pushOp),
        .pushA(pushA), .pushB(pushB), .pushShamt(pushShamt), .popTake(popTake),
        .popValid(popValid), .popOp(popOp), .popA(popA), .popB(popB),
        .popShamt(popShamt), .creditReturn(creditReturn)
    );

    execUnit unit_i (
        .Clock(Clock), .rstN(rstN), .hold(hold), .popValid(popValid), .popOp(popOp),
        .popA(popA), .popB(popB), .popShamt(popShamt), .popTake(popTake),
        .resultValid(resultValid), .result(result), .flagC(flagC), .flagZ(flagZ),
        .flagO(flagO), .flagN(flagN), .illegal(illegal)
    );

endmodule

//--- sim/execTop_assert.sv
// Execute subsystem assertions.
// Checks reset values, credit accounting against accepted and
// returned operations, queue fill after a push and the effect of hold.

`timescale 1ns/1ps
`include "exec_config.svh"

module execTopAssert (
    input logic Clock,
    input logic rstN,
    input logic hold,
    input logic inValid,
    input logic inReady,
    input logic pushValid,
    input logic popValid,
    input logic creditReturn,
    input logic resultValid
);

    localparam int CNT_W = $clog2(`EXEC_QUEUE_DEPTH + 2);

    logic [CNT_W-1:0] inFlight; // Accepted, credit not yet back.

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
            inFlight <= '0;
        else
            inFlight <= inFlight + CNT_W'(inValid && inReady) - CNT_W'(creditReturn);
    end

    // Idle one edge after reset is seen.
    resetIdle: assert property (@(posedge Clock)
        !rstN |=> (inReady && !pushValid && !popValid && !resultValid && !creditReturn))
        else $error("Outputs not idle after reset");

    // inReady high exactly while a queue entry is free.
    creditsTrackInFlight: assert property (@(posedge Clock) disable iff (!rstN)
        inReady == (inFlight < CNT_W'(`EXEC_QUEUE_DEPTH)))
        else $error("inReady disagrees with outstanding operations");

    pushFillsQueue: assert property (@(posedge Clock) disable iff (!rstN)
        pushValid |=> popValid)
        else $error("Pushed operation not at the queue head");

    holdStopsOutput: assert property (@(posedge Clock) disable iff (!rstN)
        hold |=> (!resultValid && !creditReturn))
        else $error("Result or credit while held");

endmodule

bind execTop execTopAssert execTopAssert_i (
    .Clock(Clock), .rstN(rstN), .hold(hold), .inValid(inValid), .inReady(inReady),
    .pushValid(pushValid), .popValid(popValid),
    .creditReturn(creditReturn), .resultValid(resultValid)
);

//--- sim/execTb.sv
// Execute subsystem testbench.
// Sends directed and random operations into execTop, predicts each
// result with a reference model and checks results in order.

`timescale 1ns/1ps
`include "exec_config.svh"

module execTb;

    import execPkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int ALU_OPS    = 13 * 16;
    localparam int MUL_OPS    = 2 * 16 * 3;
    localparam int MISC_OPS   = 30;       // Immediate, count, illegal, back-pressure.
    localparam int RANDOM_OPS = 300;
    localparam int TOTAL_OPS  = ALU_OPS + MUL_OPS + MISC_OPS + RANDOM_OPS;

    // First 13 are the plain ALU codes.
    localparam logic [`EXEC_FUNC_W-1:0] SPECIAL_FUNCS [17] = '{
        FN_ADD, FN_SUB, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA,
        FN_MULT, FN_MULTU, FN_MFHI, FN_MFLO
    };
    localparam logic [31:0] CORNERS [4] = '{
        32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff
    };
    localparam logic [31:0] COUNT_VALUES [5] = '{
        32'h0000_0000, 32'hffff_ffff, 32'h0000_0001, 32'h0000_8000, 32'h8000_0000
    };

    logic                     Clock;
    logic                     rstN;
    logic                     hold;
    logic                     inValid;
    logic                     aluOp;
    logic                     mulOp;
    logic [`EXEC_FUNC_W-1:0]  func;
    logic [31:0]              a;
    logic [31:0]              b;
    logic [31:0]              immediate;
    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic                     aluSrc;
    logic                     inReady;
    logic                     resultValid;
    logic [31:0]              result;
    logic                     flagC, flagZ, flagO, flagN;
    logic                     illegal;

    logic [31:0] refHi;               // Model copy of HI/LO.
    logic [31:0] refLo;
    logic [36:0] expQ [$];            // {illegal, N, O, Z, C, result}.
    logic [36:0] expected;
    logic        randomHold;

    execTop dut_i (
        .Clock(Clock), .rstN(rstN), .hold(hold), .inValid(inValid), .aluOp(aluOp),
        .mulOp(mulOp), .func(func), .a(a), .b(b), .immediate(immediate),
        .shamt(shamt), .aluSrc(aluSrc), .inReady(inReady), .resultValid(resultValid),
        .result(result), .flagC(flagC), .flagZ(flagZ), .flagO(flagO), .flagN(flagN),
        .illegal(illegal)
    );

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [36:0] predictResult(input logic aOp, input logic mOp,
            input logic [5:0] fn, input logic [31:0] x, input logic [31:0] y,
            input logic [4:0] sh);
        logic [31:0] res;
        logic [32:0] wide;
        logic [63:0] prod;
        logic        c, o, z, n, ill, isMul;
        longint      exact;
        int          k;
        res   = '0;
        prod  = '0;
        c     = 1'b0;
        o     = 1'b0;
        ill   = 1'b0;
        isMul = 1'b0;
        if (aOp && !mOp)
        begin
            case (fn)
                FN_ADD, FN_ADDU:
                begin
                    wide  = {1'b0, x} + {1'b0, y};
                    res   = wide[31:0];
                    c     = wide[32];
                    exact = longint'($signed(x)) + longint'($signed(y));
                    o     = (fn == FN_ADD) && (exact != longint'($signed(res)));
                end
                FN_SUB, FN_SUBU:
                begin
                    res   = x - y;
                    c     = (x < y);                // Borrow.
                    exact = longint'($signed(x)) - longint'($signed(y));
                    o     = (fn == FN_SUB) && (exact != longint'($signed(res)));
                end
                FN_AND:  res = x & y;
                FN_OR:   res = x | y;
                FN_XOR:  res = x ^ y;
                FN_NOR:  res = ~(x | y);
                FN_SLT:  res = {31'b0, $signed(x) < $signed(y)};
                FN_SLTU: res = {31'b0, x < y};
                FN_SLL:  res = y << sh;
                FN_SRL:  res = y >> sh;
                FN_SRA:  res = $signed(y) >>> sh;
                FN_MULT, FN_MULTU:
                begin
                    isMul = 1'b1;
                    if (fn == FN_MULT)
                        prod = longint'($signed(x)) * longint'($signed(y));
                    else
                        prod = {32'b0, x} * {32'b0, y};
                    refHi = prod[63:32];
                    refLo = prod[31:0];
                    res   = prod[31:0];
                end
                FN_MFHI: res = refHi;
                FN_MFLO: res = refLo;
                default: ill = 1'b1;
            endcase
        end
        else if (mOp && !aOp && (fn == FN_CLZ || fn == FN_CLO))
        begin
            // Walk down from the MSB while the bit matches.
            k = 31;
            while (k >= 0 && x[k] == (fn == FN_CLO))
                k = k - 1;
            res = 32'(31 - k);
        end
        else
            ill = 1'b1;
        if (ill)
        begin
            z = 1'b0;
            n = 1'b0;
        end
        else if (isMul)
        begin
            z = (prod == '0);
            n = prod[63];
        end
        else
        begin
            z = (res == '0);
            n = res[31];
        end
        return {ill, n, o, z, c, res};
    endfunction

    task automatic compareValue(input logic [31:0] actual, input logic [31:0] want,
                                input string what);
        if (actual !== want)
        begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, want);
            $display("TESTS FAILED");
            $fatal(1, "Check on %s failed", what);
        end
    endtask

    task automatic driveOp(input logic aOp, input logic mOp, input logic [5:0] fn,
            input logic [31:0] x, input logic [31:0] y, input logic [31:0] imm,
            input logic [4:0] sh, input logic src);
        aluOp     = aOp;
        mulOp     = mOp;
        func      = fn;
        a         = x;
        b         = y;
        immediate = imm;
        shamt     = sh;
        aluSrc    = src;
        inValid   = 1'b1;
    endtask

    // Holds inValid until the op is taken on a rising edge.
    task automatic waitAccept;
        @(negedge Clock);
        while (!inReady)
        begin
            @(posedge Clock);
            #10;
            if (randomHold)
                hold = (($urandom % 3) == 0);
            @(negedge Clock);
        end
        @(posedge Clock);
        #10;
        inValid = 1'b0;
        if (randomHold)
            hold = (($urandom % 3) == 0);
    endtask

    task automatic sendOp(input logic aOp, input logic mOp, input logic [5:0] fn,
            input logic [31:0] x, input logic [31:0] y, input logic [31:0] imm,
            input logic [4:0] sh, input logic src);
        driveOp(aOp, mOp, fn, x, y, imm, sh, src);
        waitAccept();
    endtask

    task automatic drainResults;
        while (expQ.size() != 0)
            @(negedge Clock);
        @(posedge Clock);
        #10;
    endtask

    // --------------------
    // Clock, watchdog, monitors
    // --------------------
    initial
    begin
        Clock = 1'b0;
        forever #(CLK_PERIOD / 2) Clock = ~Clock;
    end

    initial
    begin
        #(CLK_PERIOD * (40 * TOTAL_OPS + 200));
        $display("Timeout: the run did not finish within the cycle budget");
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    // Inputs are stable at the falling edge before the accepting edge.
    always @(negedge Clock)
    begin
        if (rstN && inValid && inReady)
            expQ.push_back(predictResult(aluOp, mulOp, func, a,
                                         aluSrc ? immediate : b, shamt));
    end

    always @(negedge Clock)
    begin
        if (rstN && resultValid)
        begin
            if (expQ.size() == 0)
            begin
                $display("A result arrived with no operation outstanding");
                $display("TESTS FAILED");
                $fatal(1, "Unexpected result");
            end
            else
            begin
                expected = expQ.pop_front();
                compareValue(result, expected[31:0], "result");
                compareValue(32'(flagC), 32'(expected[32]), "flagC");
                compareValue(32'(flagZ), 32'(expected[33]), "flagZ");
                compareValue(32'(flagO), 32'(expected[34]), "flagO");
                compareValue(32'(flagN), 32'(expected[35]), "flagN");
                compareValue(32'(illegal), 32'(expected[36]), "illegal");
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin
        int i;
        int j;
        int k;
        int pick;
        int drain;
        void'($urandom(32'hcacced65));
        rstN       = 1'b0;
        hold       = 1'b0;
        randomHold = 1'b0;
        refHi      = '0;
        refLo      = '0;
        driveOp(1'b0, 1'b0, '0, '0, '0, '0, '0, 1'b0);
        inValid = 1'b0;
        repeat (3) @(posedge Clock);
        #10;
        rstN = 1'b1;
        @(negedge Clock);
        compareValue(32'(inReady), 32'd1, "inReady after reset");
        compareValue(32'(resultValid), 32'd0, "resultValid after reset");
        @(posedge Clock);
        #10;

        // Directed ALU codes over corner operands.
        for (i = 0; i < 13; i++)
            for (j = 0; j < 4; j++)
                for (k = 0; k < 4; k++)
                    sendOp(1'b1, 1'b0, SPECIAL_FUNCS[i], CORNERS[j], CORNERS[k], 32'h0,
                           5'(i * 3 + j * 8 + k), 1'b0);

        // Immediate replaces B.
        sendOp(1'b1, 1'b0, FN_ADD, 32'd5, 32'd1000, 32'h10, 5'd0, 1'b1);
        sendOp(1'b1, 1'b0, FN_SUB, 32'd5, 32'd1, 32'h7fff_ffff, 5'd0, 1'b1);
        sendOp(1'b1, 1'b0, FN_OR, 32'hf000_0000, 32'hffff, 32'h0f0f, 5'd0, 1'b1);
        sendOp(1'b1, 1'b0, FN_SLL, 32'd0, 32'd1, 32'h3, 5'd4, 1'b1);

        // Multiply, then read both halves.
        for (i = 0; i < 2; i++)
            for (j = 0; j < 4; j++)
                for (k = 0; k < 4; k++)
                begin
                    sendOp(1'b1, 1'b0, (i == 0) ? FN_MULT : FN_MULTU, CORNERS[j],
                           CORNERS[k], 32'h0, 5'd0, 1'b0);
                    sendOp(1'b1, 1'b0, FN_MFHI, '0, '0, '0, 5'd0, 1'b0);
                    sendOp(1'b1, 1'b0, FN_MFLO, '0, '0, '0, 5'd0, 1'b0);
                end

        for (i = 0; i < 5; i++)
        begin
            sendOp(1'b0, 1'b1, FN_CLZ, COUNT_VALUES[i], '0, '0, 5'd0, 1'b0);
            sendOp(1'b0, 1'b1, FN_CLO, COUNT_VALUES[i], '0, '0, 5'd0, 1'b0);
        end

        // Unused code, SPECIAL2 miss, both tables, no table.
        sendOp(1'b1, 1'b0, 6'h3f, 32'd1, 32'd2, '0, 5'd0, 1'b0);
        sendOp(1'b0, 1'b1, 6'h05, 32'd1, 32'd2, '0, 5'd0, 1'b0);
        sendOp(1'b1, 1'b1, FN_ADD, 32'd1, 32'd2, '0, 5'd0, 1'b0);
        sendOp(1'b0, 1'b0, FN_ADD, 32'd1, 32'd2, '0, 5'd0, 1'b0);

        // --------------------
        // Back-pressure
        // --------------------
        drainResults();
        hold = 1'b1;
        for (i = 0; i < `EXEC_QUEUE_DEPTH; i++)
            sendOp(1'b1, 1'b0, FN_ADDU, 32'(i), 32'd100, '0, 5'd0, 1'b0);
        driveOp(1'b1, 1'b0, FN_XOR, 32'h1234_5678, 32'hffff_0000, '0, 5'd0, 1'b0);
        repeat (4)
        begin
            @(negedge Clock);
            compareValue(32'(inReady), 32'd0, "inReady with queue full");
            compareValue(32'(resultValid), 32'd0, "resultValid under hold");
        end
        @(posedge Clock);
        #10;
        hold = 1'b0;
        waitAccept();

        // Random run with hold toggling.
        randomHold = 1'b1;
        for (i = 0; i < RANDOM_OPS; i++)
        begin
            pick = $urandom % 20;
            if (pick < 17)
                sendOp(1'b1, 1'b0, SPECIAL_FUNCS[pick], $urandom, $urandom, $urandom,
                       5'($urandom), 1'($urandom));
            else if (pick == 17)
                sendOp(1'b0, 1'b1, ($urandom % 2) ? FN_CLO : FN_CLZ, $urandom >> ($urandom % 32),
                       $urandom, $urandom, 5'($urandom), 1'b0);
            else
                sendOp(1'($urandom), 1'($urandom), 6'($urandom), $urandom, $urandom,
                       $urandom, 5'($urandom), 1'($urandom));
        end
        randomHold = 1'b0;
        hold       = 1'b0;

        drain = 0;
        while (expQ.size() != 0 && drain < 200)
        begin
            @(negedge Clock);
            drain++;
        end
        repeat (4) @(negedge Clock);     // Catch a stray extra result.
        if (expQ.size() == 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("The run ended with %0d results missing", expQ.size());
            $display("TESTS FAILED");
            $fatal(1, "Missing results");
        end
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/execPkg.sv
rtl/aluCore.sv
rtl/execIssue.sv
rtl/execQueue.sv
rtl/execUnit.sv
rtl/execTop.sv
sim/execTop_assert.sv
sim/execTb.sv

//--- run.sh
#!/bin/sh
# Build the execute subsystem testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module execTb -o execSim

./obj_dir/execSim | tee sim.log

if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
